//--- Makefile
# Verilator build and run for the key/value lookup table testbench
TOP = kv_lookup_tb

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): kv_lookup_top.f src/*.sv src/*.svh verification/*.sv
	verilator --binary --timing --assert -f kv_lookup_top.f --top-module $(TOP) -Mdir obj_dir

# a failing check ends in $fatal, which gives a nonzero exit status
run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

//--- kv_lookup_top.f
+incdir+src
src/kv_pkg.sv
src/kv_priority_encode.sv
src/kv_cam.sv
src/kv_value_ram.sv
src/kv_replace_counter.sv
src/kv_ctrl_fsm.sv
src/kv_lookup_top.sv
verification/kv_lookup_tb.sv

//--- src/kv_cam.sv
// content addressable key store with valid bits, searched every cycle by the lookup controller
`include "kv_consts.svh"

module kv_cam
  import kv_pkg::*;
(
  input  logic        clk_i,
  input  logic        reset_i,
  input  cam_write_s  write_i,
  input  key_t        search_key_i,
  output cam_result_s match_o,
  output cam_result_s empty_o
);

  // stored keys, only meaningful where the matching valid bit is set
  key_t key_mem [`KV_ENTRIES];

  // one valid bit per entry, cleared on reset
  logic [`KV_ENTRIES-1:0] valid_q;

  // per-entry flags that feed the two encoders
  logic [`KV_ENTRIES-1:0] match_vec;
  logic [`KV_ENTRIES-1:0] empty_vec;

  // valid bits follow the set/clear flag of the write port
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= '0;
    end else if (write_i.v) begin
      valid_q[write_i.addr] <= write_i.set_not_clear;
    end
  end

  // the key is only stored when an entry is being filled
  // a clear leaves the stale key behind, the valid bit masks it
  always_ff @(posedge clk_i) begin
    if (write_i.v && write_i.set_not_clear) begin
      key_mem[write_i.addr] <= write_i.key;
    end
  end

  // compare the search key against every valid entry in parallel
  // an invalid entry never matches and always counts as empty
  always_comb begin
    for (int i = 0; i < `KV_ENTRIES; i++) begin
      match_vec[i] = valid_q[i] && (key_mem[i] == search_key_i);
      empty_vec[i] = ~valid_q[i];
    end
  end

  // the controller never stores a key twice, so at most one bit is set here
  // and the lowest-index pick only matters as a defined tie break
  kv_priority_encode match_pe (
    .vec_i    (match_vec),
    .result_o (match_o)
  );

  // lowest free slot, used by insert when the key is not yet present
  kv_priority_encode empty_pe (
    .vec_i    (empty_vec),
    .result_o (empty_o)
  );

endmodule

//--- src/kv_consts.svh
// sizing macros for the key/value lookup table, included by every file that needs a width or depth
`ifndef KV_CONSTS_SVH
`define KV_CONSTS_SVH

// number of table entries, each one a CAM slot with a matching value slot
`define KV_ENTRIES 8
// width of a lookup key
`define KV_KEY_W 12
// width of the value stored with each key
`define KV_VAL_W 16
// entry index width, log2 of KV_ENTRIES
`define KV_ADDR_W 3

`endif

//--- src/kv_ctrl_fsm.sv
// command controller of the lookup table, it probes the CAM and sequences writes and responses
module kv_ctrl_fsm
  import kv_pkg::*;
(
  input  logic        clk_i,
  input  logic        reset_i,
  input  logic        lookup_v_i,
  input  key_t        lookup_key_i,
  input  logic        insert_v_i,
  input  key_t        insert_key_i,
  input  val_t        insert_val_i,
  input  logic        inval_v_i,
  input  key_t        inval_key_i,
  input  cam_result_s match_i,
  input  cam_result_s empty_i,
  input  addr_t       victim_addr_i,
  output key_t        search_key_o,
  output cam_write_s  cam_write_o,
  output ram_write_s  ram_write_o,
  output logic        ram_rd_v_o,
  output addr_t       ram_rd_addr_o,
  output logic        replace_adv_o,
  output logic        inc_o,
  output logic        dec_o,
  output logic        busy_o,
  output logic        resp_v_o,
  output logic        resp_hit_o
);

  ctrl_state_e state_q;
  ctrl_state_e state_n;

  // command payload latched when the command is taken
  key_t key_q;
  val_t val_q;

  // write decision made in the probe state and applied in WRITE
  addr_t wr_addr_q;
  logic  wr_set_q;
  logic  wr_inc_q;
  logic  wr_adv_q;

  // lookup pipeline, first the RAM read stage and then the response stage
  logic  lk_v_q;
  logic  lk_hit_q;
  addr_t rd_addr_q;
  logic  resp_v_q;
  logic  resp_hit_q;

  logic idle;
  logic in_write;
  logic take_inval;
  logic take_insert;
  logic take_lookup;

  assign idle     = (state_q == IDLE);
  assign in_write = (state_q == WRITE);

  // invalidate beats insert and insert beats lookup, the losers are dropped
  assign take_inval  = idle && inval_v_i;
  assign take_insert = idle && insert_v_i && !inval_v_i;
  assign take_lookup = idle && lookup_v_i && !insert_v_i && !inval_v_i;

  // in IDLE the CAM sees the key of whichever command would win this cycle
  always_comb begin
    if (!idle) begin
      search_key_o = key_q;
    end else if (inval_v_i) begin
      search_key_o = inval_key_i;
    end else if (insert_v_i) begin
      search_key_o = insert_key_i;
    end else begin
      search_key_o = lookup_key_i;
    end
  end

  always_comb begin
    state_n = state_q;
    case (state_q)
      IDLE: begin
        if (take_inval) begin
          state_n = PROBE_INVAL;
        end else if (take_insert) begin
          state_n = PROBE_INSERT;
        end
      end
      // an insert always writes, either an update, an empty slot or the victim
      PROBE_INSERT: state_n = WRITE;
      // an invalidate of an absent key ends here with nothing to do
      PROBE_INVAL: state_n = match_i.v ? WRITE : IDLE;
      WRITE: state_n = IDLE;
      default: state_n = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q  <= IDLE;
      lk_v_q   <= 1'b0;
      resp_v_q <= 1'b0;
    end else begin
      state_q  <= state_n;
      lk_v_q   <= take_lookup;
      resp_v_q <= lk_v_q;
    end
  end

  // payload, write decision and lookup data registers
  // each one is only used while the state or a valid bit above marks it live
  always_ff @(posedge clk_i) begin
    if (take_inval) begin
      key_q    <= inval_key_i;
      wr_set_q <= 1'b0;
    end else if (take_insert) begin
      key_q    <= insert_key_i;
      val_q    <= insert_val_i;
      wr_set_q <= 1'b1;
    end
    if (state_q == PROBE_INSERT) begin
      // an existing key is updated in place and leaves the count alone
      if (match_i.v) begin
        wr_addr_q <= match_i.addr;
        wr_inc_q  <= 1'b0;
        wr_adv_q  <= 1'b0;
      end else if (empty_i.v) begin
        wr_addr_q <= empty_i.addr;
        wr_inc_q  <= 1'b1;
        wr_adv_q  <= 1'b0;
      end else begin
        // the table is full, so the round-robin victim is overwritten
        wr_addr_q <= victim_addr_i;
        wr_inc_q  <= 1'b0;
        wr_adv_q  <= 1'b1;
      end
    end else if (state_q == PROBE_INVAL) begin
      wr_addr_q <= match_i.addr;
      wr_inc_q  <= 1'b0;
      wr_adv_q  <= 1'b0;
    end
    // the lookup hit and entry index move on to the RAM read stage
    if (take_lookup) begin
      lk_hit_q  <= match_i.v;
      rd_addr_q <= match_i.addr;
    end
    resp_hit_q <= lk_hit_q;
  end

  // the CAM either fills or clears the target entry
  always_comb begin
    cam_write_o.v             = in_write;
    cam_write_o.set_not_clear = wr_set_q;
    cam_write_o.addr          = wr_addr_q;
    cam_write_o.key           = key_q;
  end

  // only inserts touch the value RAM
  always_comb begin
    ram_write_o.v     = in_write && wr_set_q;
    ram_write_o.addr  = wr_addr_q;
    ram_write_o.value = val_q;
  end

  assign ram_rd_v_o    = lk_v_q;
  assign ram_rd_addr_o = rd_addr_q;

  assign inc_o         = in_write && wr_inc_q;
  assign dec_o         = in_write && !wr_set_q;
  assign replace_adv_o = in_write && wr_adv_q;

  assign busy_o     = !idle;
  assign resp_v_o   = resp_v_q;
  assign resp_hit_o = resp_hit_q;

endmodule

//--- src/kv_lookup_top.sv
// top level of the key/value lookup table, joining the controller, CAM, value RAM and counter
module kv_lookup_top
  import kv_pkg::*;
(
  input  logic   clk_i,
  input  logic   reset_i,
  input  logic   lookup_v_i,
  input  key_t   lookup_key_i,
  input  logic   insert_v_i,
  input  key_t   insert_key_i,
  input  val_t   insert_val_i,
  input  logic   inval_v_i,
  input  key_t   inval_key_i,
  output logic   busy_o,
  output logic   resp_v_o,
  output logic   resp_hit_o,
  output val_t   resp_val_o,
  output count_t count_o
);

  // CAM side of the controller
  key_t        search_key;
  cam_result_s match;
  cam_result_s empty;
  cam_write_s  cam_write;

  // value RAM side
  ram_write_s ram_write;
  logic       ram_rd_v;
  addr_t      ram_rd_addr;

  // replacement and occupancy
  logic  replace_adv;
  logic  inc;
  logic  dec;
  addr_t victim_addr;

  kv_ctrl_fsm ctrl0 (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .lookup_v_i    (lookup_v_i),
    .lookup_key_i  (lookup_key_i),
    .insert_v_i    (insert_v_i),
    .insert_key_i  (insert_key_i),
    .insert_val_i  (insert_val_i),
    .inval_v_i     (inval_v_i),
    .inval_key_i   (inval_key_i),
    .match_i       (match),
    .empty_i       (empty),
    .victim_addr_i (victim_addr),
    .search_key_o  (search_key),
    .cam_write_o   (cam_write),
    .ram_write_o   (ram_write),
    .ram_rd_v_o    (ram_rd_v),
    .ram_rd_addr_o (ram_rd_addr),
    .replace_adv_o (replace_adv),
    .inc_o         (inc),
    .dec_o         (dec),
    .busy_o        (busy_o),
    .resp_v_o      (resp_v_o),
    .resp_hit_o    (resp_hit_o)
  );

  kv_cam cam0 (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .write_i      (cam_write),
    .search_key_i (search_key),
    .match_o      (match),
    .empty_o      (empty)
  );

  // the read register lines up with the response stage of the controller
  kv_value_ram ram0 (
    .clk_i     (clk_i),
    .write_i   (ram_write),
    .rd_v_i    (ram_rd_v),
    .rd_addr_i (ram_rd_addr),
    .rd_val_o  (resp_val_o)
  );

  kv_replace_counter repl0 (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .replace_adv_i (replace_adv),
    .inc_i         (inc),
    .dec_i         (dec),
    .victim_addr_o (victim_addr),
    .count_o       (count_o)
  );

endmodule

//--- src/kv_pkg.sv
// shared types for the key/value lookup table, imported by each RTL module that uses them
`include "kv_consts.svh"

package kv_pkg;

  // plain vectors for the widths that carry a meaning
  typedef logic [`KV_KEY_W-1:0] key_t;
  typedef logic [`KV_VAL_W-1:0] val_t;
  typedef logic [`KV_ADDR_W-1:0] addr_t;
  // one extra bit so a full table can report KV_ENTRIES
  typedef logic [`KV_ADDR_W:0] count_t;

  // controller states, a command spends at most one cycle in each of them
  typedef enum logic [1:0] {
    IDLE,
    PROBE_INSERT,
    PROBE_INVAL,
    WRITE
  } ctrl_state_e;

  // CAM write command, set_not_clear low turns the addressed entry invalid
  typedef struct packed {
    logic v;
    logic set_not_clear;
    addr_t addr;
    key_t key;
  } cam_write_s;

  // search result, used for both the match and the empty-entry outputs
  typedef struct packed {
    logic v;
    addr_t addr;
  } cam_result_s;

  // value RAM write, the address is always a CAM entry index
  typedef struct packed {
    logic v;
    addr_t addr;
    val_t value;
  } ram_write_s;

endpackage

//--- src/kv_priority_encode.sv
// lowest-set-bit encoder over one bit per table entry, used by the CAM for match and empty search
`include "kv_consts.svh"

module kv_priority_encode
  import kv_pkg::*;
(
  input  logic [`KV_ENTRIES-1:0] vec_i,
  output cam_result_s            result_o
);

  // valid whenever any entry flag is raised
  assign result_o.v = |vec_i;

  // walk from the top index down so the lowest set bit is the last one to win
  // when nothing is set the index stays at zero and only the valid flag tells
  always_comb begin
    result_o.addr = '0;
    for (int i = `KV_ENTRIES - 1; i >= 0; i--) begin
      if (vec_i[i]) begin
        result_o.addr = addr_t'(i);
      end
    end
  end

endmodule

//--- src/kv_replace_counter.sv
// round-robin victim pointer and occupancy counter, stepped by the controller during writes
`include "kv_consts.svh"

module kv_replace_counter
  import kv_pkg::*;
(
  input  logic   clk_i,
  input  logic   reset_i,
  input  logic   replace_adv_i,
  input  logic   inc_i,
  input  logic   dec_i,
  output addr_t  victim_addr_o,
  output count_t count_o
);

  // highest entry index, the pointer wraps back to zero after it
  localparam addr_t LAST_ADDR = addr_t'(`KV_ENTRIES - 1);

  addr_t  victim_q;
  count_t count_q;

  // the victim only moves when a full table had to evict an entry
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      victim_q <= '0;
    end else if (replace_adv_i) begin
      if (victim_q == LAST_ADDR) begin
        victim_q <= '0;
      end else begin
        victim_q <= victim_q + addr_t'(1);
      end
    end
  end

  // occupancy follows inserts into empty slots and invalidate hits
  // both pulses together cancel out, though the controller never raises both
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count_q <= '0;
    end else begin
      case ({inc_i, dec_i})
        2'b10:   count_q <= count_q + count_t'(1);
        2'b01:   count_q <= count_q - count_t'(1);
        default: count_q <= count_q;
      endcase
    end
  end

  assign victim_addr_o = victim_q;
  assign count_o       = count_q;

endmodule

//--- src/kv_value_ram.sv
// value storage indexed by CAM entry, written by insert and read for each lookup
`include "kv_consts.svh"

module kv_value_ram
  import kv_pkg::*;
(
  input  logic       clk_i,
  input  ram_write_s write_i,
  input  logic       rd_v_i,
  input  addr_t      rd_addr_i,
  output val_t       rd_val_o
);

  // one value per CAM entry
  // a value only counts while the CAM valid bit of its entry is set
  val_t val_mem [`KV_ENTRIES];

  // read data register, it holds until the next lookup reaches the read stage
  val_t rd_val_q;

  // synchronous write from the controller WRITE state
  always_ff @(posedge clk_i) begin
    if (write_i.v) begin
      val_mem[write_i.addr] <= write_i.value;
    end
  end

  // registered read, only updated on edges that carry a lookup
  always_ff @(posedge clk_i) begin
    if (rd_v_i) begin
      rd_val_q <= val_mem[rd_addr_i];
    end
  end

  assign rd_val_o = rd_val_q;

endmodule

//--- verification/kv_lookup_tb.sv
// self-checking testbench for the key/value lookup table, built and run through the Makefile
`include "kv_consts.svh"

module kv_lookup_tb
  import kv_pkg::*;
();

  localparam int DRIVE_DLY    = 10;
  localparam int IDLE_TIMEOUT = 20;
  localparam int RANDOM_CMDS  = 300;

  logic   clk_i = 1'b0;
  logic   reset_i;
  logic   lookup_v_i;
  key_t   lookup_key_i;
  logic   insert_v_i;
  key_t   insert_key_i;
  val_t   insert_val_i;
  logic   inval_v_i;
  key_t   inval_key_i;
  logic   busy_o;
  logic   resp_v_o;
  logic   resp_hit_o;
  val_t   resp_val_o;
  count_t count_o;

  // reference model of the table contents and the replacement pointer
  key_t   m_key [`KV_ENTRIES];
  val_t   m_val [`KV_ENTRIES];
  logic   m_valid [`KV_ENTRIES];
  addr_t  m_victim;
  count_t m_count;

  // expected response of the lookup that sits on the inputs right now
  logic exp_hit;
  val_t exp_val;

  // accepted commands, following the priority rule of the table
  logic lk_acc;
  logic ins_acc;
  logic inv_acc;

  // delayed copies that line up with the DUT response and busy timing
  logic lk_q1;
  logic lk_q2;
  logic hit_q1;
  logic hit_q2;
  val_t val_q1;
  val_t val_q2;
  logic ins_q1;
  logic ins_q2;
  logic ins_q3;
  logic cmd_seen;

  // model occupancy delayed to the edge where the DUT count should show it
  count_t cnt_q1;
  count_t cnt_q2;

  int seed;

  kv_lookup_top dut0 (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .lookup_v_i   (lookup_v_i),
    .lookup_key_i (lookup_key_i),
    .insert_v_i   (insert_v_i),
    .insert_key_i (insert_key_i),
    .insert_val_i (insert_val_i),
    .inval_v_i    (inval_v_i),
    .inval_key_i  (inval_key_i),
    .busy_o       (busy_o),
    .resp_v_o     (resp_v_o),
    .resp_hit_o   (resp_hit_o),
    .resp_val_o   (resp_val_o),
    .count_o      (count_o)
  );

  always #50 clk_i = ~clk_i;

  // invalidate beats insert and insert beats lookup
  // strobes are only raised once the table is idle, so the winning one is always taken
  assign lk_acc  = lookup_v_i && !insert_v_i && !inval_v_i;
  assign ins_acc = insert_v_i && !inval_v_i;
  assign inv_acc = inval_v_i;

  always @(posedge clk_i) begin
    if (reset_i) begin
      lk_q1    <= 1'b0;
      lk_q2    <= 1'b0;
      ins_q1   <= 1'b0;
      ins_q2   <= 1'b0;
      ins_q3   <= 1'b0;
      cmd_seen <= 1'b0;
      cnt_q1   <= '0;
      cnt_q2   <= '0;
    end else begin
      lk_q1  <= lk_acc;
      lk_q2  <= lk_q1;
      hit_q1 <= exp_hit;
      hit_q2 <= hit_q1;
      val_q1 <= exp_val;
      val_q2 <= val_q1;
      ins_q1 <= ins_acc;
      ins_q2 <= ins_q1;
      ins_q3 <= ins_q2;
      cnt_q1 <= m_count;
      cnt_q2 <= cnt_q1;
      if (ins_acc || inv_acc) begin
        cmd_seen <= 1'b1;
      end
    end
  end

  // one response pulse per accepted lookup, two edges after it was taken
  resp_v_chk: assert property (@(posedge clk_i) disable iff (reset_i) resp_v_o == lk_q2)
    else report_mismatch("resp_v_o", 32'($sampled(resp_v_o)), 32'($sampled(lk_q2)));

  resp_hit_chk: assert property (@(posedge clk_i) disable iff (reset_i)
    lk_q2 |-> resp_hit_o == hit_q2)
    else report_mismatch("resp_hit_o", 32'($sampled(resp_hit_o)), 32'($sampled(hit_q2)));

  // the value only carries meaning on a hit
  resp_val_chk: assert property (@(posedge clk_i) disable iff (reset_i)
    (lk_q2 && hit_q2) |-> resp_val_o == val_q2)
    else report_mismatch("resp_val_o", 32'($sampled(resp_val_o)), 32'($sampled(val_q2)));

  // the DUT count moves at the write, two edges after the model took the command
  count_chk: assert property (@(posedge clk_i) disable iff (reset_i) count_o == cnt_q2)
    else report_mismatch("count_o", 32'($sampled(count_o)), 32'($sampled(cnt_q2)));

  idle_chk: assert property (@(posedge clk_i) disable iff (reset_i) !cmd_seen |-> !busy_o)
    else stop_run("busy_o went high before any command was accepted");

  // an insert occupies the probe cycle and the write cycle, then releases
  ins_busy_chk: assert property (@(posedge clk_i) disable iff (reset_i)
    (ins_q1 || ins_q2) |-> busy_o)
    else stop_run("busy_o fell before an insert had finished");

  ins_done_chk: assert property (@(posedge clk_i) disable iff (reset_i) ins_q3 |-> !busy_o)
    else stop_run("busy_o stayed high longer than two cycles after an insert");

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    stop_run($sformatf("ERR %s got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  // index of a stored key, or -1 when absent
  function automatic int find_key(input key_t k);
    for (int i = 0; i < `KV_ENTRIES; i++) begin
      if (m_valid[i] && m_key[i] == k) begin
        return i;
      end
    end
    return -1;
  endfunction

  function automatic int find_empty();
    for (int i = 0; i < `KV_ENTRIES; i++) begin
      if (!m_valid[i]) begin
        return i;
      end
    end
    return -1;
  endfunction

  // update in place, else the lowest free entry, else the round-robin victim
  task automatic model_insert(input key_t k, input val_t v);
    int idx;
    idx = find_key(k);
    if (idx < 0) begin
      idx = find_empty();
      if (idx >= 0) begin
        m_count = m_count + count_t'(1);
      end else begin
        idx = int'(m_victim);
        m_victim = addr_t'((int'(m_victim) + 1) % `KV_ENTRIES);
      end
    end
    m_key[idx]   = k;
    m_val[idx]   = v;
    m_valid[idx] = 1'b1;
  endtask

  task automatic model_inval(input key_t k);
    int idx;
    idx = find_key(k);
    if (idx >= 0) begin
      m_valid[idx] = 1'b0;
      m_count = m_count - count_t'(1);
    end
  endtask

  task automatic wait_idle();
    int cycles;
    cycles = 0;
    while (busy_o && cycles < IDLE_TIMEOUT) begin
      @(posedge clk_i);
      #DRIVE_DLY;
      cycles++;
    end
    if (busy_o) begin
      stop_run("timeout while waiting for busy_o to fall");
    end
  endtask

  // key_a feeds lookup and insert, key_b feeds invalidate
  task automatic issue_cmd(input logic do_lk, input logic do_ins, input logic do_inv,
                           input key_t key_a, input key_t key_b, input val_t value);
    int idx;
    lookup_v_i   = do_lk;
    lookup_key_i = key_a;
    insert_v_i   = do_ins;
    insert_key_i = key_a;
    insert_val_i = value;
    inval_v_i    = do_inv;
    inval_key_i  = key_b;
    // a lookup only sets expectations when it is the winning strobe
    if (do_lk && !do_ins && !do_inv) begin
      idx = find_key(key_a);
      exp_hit = (idx >= 0);
      if (idx >= 0) begin
        exp_val = m_val[idx];
      end else begin
        exp_val = '0;
      end
    end
    @(posedge clk_i);
    #DRIVE_DLY;
    lookup_v_i = 1'b0;
    insert_v_i = 1'b0;
    inval_v_i  = 1'b0;
    if (do_inv) begin
      model_inval(key_b);
      wait_idle();
    end else if (do_ins) begin
      model_insert(key_a, value);
      wait_idle();
    end
  endtask

  task automatic lookup_key(input key_t k);
    issue_cmd(1'b1, 1'b0, 1'b0, k, k, '0);
  endtask

  task automatic insert_pair(input key_t k, input val_t v);
    issue_cmd(1'b0, 1'b1, 1'b0, k, k, v);
  endtask

  task automatic invalidate_key(input key_t k);
    issue_cmd(1'b0, 1'b0, 1'b1, k, k, '0);
  endtask

  initial begin
    logic [31:0] r;
    logic [3:0]  op;
    key_t        key_a;
    key_t        key_b;
    seed         = 56;
    reset_i      = 1'b1;
    lookup_v_i   = 1'b0;
    lookup_key_i = '0;
    insert_v_i   = 1'b0;
    insert_key_i = '0;
    insert_val_i = '0;
    inval_v_i    = 1'b0;
    inval_key_i  = '0;
    exp_hit      = 1'b0;
    exp_val      = '0;
    m_victim     = '0;
    m_count      = '0;
    for (int i = 0; i < `KV_ENTRIES; i++) begin
      m_key[i]   = '0;
      m_val[i]   = '0;
      m_valid[i] = 1'b0;
    end
    repeat (5) @(posedge clk_i);
    #DRIVE_DLY;
    reset_i = 1'b0;

    // an empty table misses on every key
    lookup_key(12'h000);
    lookup_key(12'h101);
    lookup_key(12'hfff);

    // distinct keys, then back-to-back lookups of all of them
    for (int i = 1; i <= 5; i++) begin
      insert_pair(key_t'(12'h100 + i), val_t'({4'ha, key_t'(12'h100 + i)}));
    end
    for (int i = 0; i <= 6; i++) begin
      lookup_key(key_t'(12'h100 + i));
    end

    // rewriting a present key only changes its value
    insert_pair(12'h103, 16'h5a5a);
    lookup_key(12'h103);

    // fill the table, then evict entries 0, 1 and 2 in turn
    for (int i = 6; i <= 8; i++) begin
      insert_pair(key_t'(12'h100 + i), val_t'({4'hb, key_t'(12'h100 + i)}));
    end
    insert_pair(12'h201, 16'h2001);
    insert_pair(12'h202, 16'h2002);
    insert_pair(12'h203, 16'h2003);
    for (int i = 1; i <= 8; i++) begin
      lookup_key(key_t'(12'h100 + i));
    end
    lookup_key(12'h201);
    lookup_key(12'h203);

    // free two entries, miss on an absent key, then refill the lowest hole
    invalidate_key(12'h105);
    invalidate_key(12'h107);
    invalidate_key(12'h999);
    lookup_key(12'h105);
    insert_pair(12'h301, 16'h3001);
    lookup_key(12'h301);

    // with both strobes high only the invalidate takes effect
    issue_cmd(1'b0, 1'b1, 1'b1, 12'h302, 12'h104, 16'hbeef);
    lookup_key(12'h104);
    lookup_key(12'h302);
    insert_pair(12'h303, 16'h3003);
    insert_pair(12'h304, 16'h3004);
    insert_pair(12'h305, 16'h3005);
    for (int i = 1; i <= 5; i++) begin
      lookup_key(key_t'(12'h300 + i));
    end

    // random mix over twelve keys, so the table keeps filling and evicting
    for (int n = 0; n < RANDOM_CMDS; n++) begin
      r     = $random(seed);
      op    = r[7:4];
      key_a = key_t'(12'h200 + 12'(r[3:0] % 4'd12));
      key_b = key_t'(12'h200 + 12'(r[11:8] % 4'd12));
      if (op < 4'd6) begin
        issue_cmd(1'b1, 1'b0, 1'b0, key_a, key_b, r[31:16]);
      end else if (op < 4'd11) begin
        issue_cmd(1'b0, 1'b1, 1'b0, key_a, key_b, r[31:16]);
      end else if (op < 4'd14) begin
        issue_cmd(1'b0, 1'b0, 1'b1, key_a, key_b, r[31:16]);
      end else if (op == 4'd14) begin
        issue_cmd(1'b0, 1'b1, 1'b1, key_a, key_b, r[31:16]);
      end else begin
        issue_cmd(1'b1, 1'b1, 1'b0, key_a, key_b, r[31:16]);
      end
    end

    // the last lookups leave the response stage within two edges
    repeat (3) @(posedge clk_i);
    $display("No errors");
    $finish;
  end

endmodule
